/* source/mem_pkg.sv */
package mem_pkg;

    // Low address bits that pick a byte lane in a bus word
    localparam int LANE_BITS = 2;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    // Encoding seen on data_size_o
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

    // Same values as the MIPS cause ExcCode field
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_e;

    // Returned bus word, by byte lane or by halfword
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } bus_word_u;

endpackage

/* source/mem_access_if.sv */
interface mem_access_if;
    import mem_pkg::*;

    logic      req;
    logic      wr;
    acc_size_e size;
    word_t     addr;
    word_t     wdata;
    mem_op_e   op;
    reg_addr_t rd;

    modport decoder (
        output req,
        output wr,
        output size,
        output addr,
        output wdata,
        output op,
        output rd
    );

    modport ctrl (
        input req,
        input wr,
        input size,
        input addr,
        input wdata,
        input op,
        input rd
    );

endinterface

/* source/mem_access_decode.sv */
module mem_access_decode (
    input  logic               valid_i,
    input  mem_pkg::mem_op_e   op_i,
    input  mem_pkg::word_t     addr_i,
    input  mem_pkg::word_t     store_data_i,
    input  mem_pkg::reg_addr_t rd_i,
    output mem_pkg::exc_code_e exc_o,
    mem_access_if.decoder      acc
);
    import mem_pkg::*;

    logic      is_mem;
    logic      is_store;
    logic      misaligned;
    acc_size_e size;
    word_t     lane_data;

    always_comb begin
        is_mem     = 1'b1;
        is_store   = 1'b0;
        misaligned = 1'b0;
        size       = SIZE_WORD;
        lane_data  = store_data_i;
        case (op_i)
            OP_LB, OP_LBU: begin
                size = SIZE_BYTE;
            end
            OP_LH, OP_LHU: begin
                size       = SIZE_HALF;
                misaligned = addr_i[0];
            end
            OP_LW: begin
                misaligned = |addr_i[LANE_BITS-1:0];
            end
            OP_SB: begin
                is_store  = 1'b1;
                size      = SIZE_BYTE;
                // Same byte on every lane, memory picks by address
                lane_data = {4{store_data_i[7:0]}};
            end
            OP_SH: begin
                is_store   = 1'b1;
                size       = SIZE_HALF;
                misaligned = addr_i[0];
                lane_data  = {2{store_data_i[15:0]}};
            end
            OP_SW: begin
                is_store   = 1'b1;
                misaligned = |addr_i[LANE_BITS-1:0];
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
    end

    // Misaligned accesses never reach the bus
    assign acc.req   = valid_i && is_mem && !misaligned;
    assign acc.wr    = is_store;
    assign acc.size  = size;
    assign acc.addr  = addr_i;
    assign acc.wdata = lane_data;
    assign acc.op    = op_i;
    assign acc.rd    = rd_i;

    always_comb begin
        exc_o = EXC_NONE;
        if (valid_i && is_mem && misaligned) begin
            exc_o = is_store ? EXC_ADES : EXC_ADEL;
        end
    end

endmodule

/* source/mem_bus_ctrl.sv */
module mem_bus_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            data_addr_ok_i,
    input  logic                            data_data_ok_i,
    mem_access_if.ctrl                      acc,
    output logic                            data_req_o,
    output logic                            data_wr_o,
    output mem_pkg::acc_size_e              data_size_o,
    output mem_pkg::word_t                  data_addr_o,
    output mem_pkg::word_t                  data_wdata_o,
    output logic                            stall_o,
    output logic                            load_done_o,
    output mem_pkg::mem_op_e                saved_op_o,
    output logic [mem_pkg::LANE_BITS-1:0]   saved_lane_o,
    output mem_pkg::reg_addr_t              saved_rd_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ADDR,
        ST_WAIT_DATA
    } state_e;

    state_e state;

    // Request captured when it first goes out
    logic      saved_wr;
    acc_size_e saved_size;
    word_t     saved_addr;
    word_t     saved_wdata;
    mem_op_e   saved_op;
    reg_addr_t saved_rd;

    logic idle;
    logic start;

    assign idle  = (state == ST_IDLE);
    assign start = idle && acc.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (acc.req) begin
                        state <= data_addr_ok_i ? ST_WAIT_DATA : ST_WAIT_ADDR;
                    end
                end
                ST_WAIT_ADDR: begin
                    if (data_addr_ok_i) begin
                        state <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA: begin
                    if (data_data_ok_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            saved_wr    <= acc.wr;
            saved_size  <= acc.size;
            saved_addr  <= acc.addr;
            saved_wdata <= acc.wdata;
            saved_op    <= acc.op;
            saved_rd    <= acc.rd;
        end
    end

    // Live request while idle, held copy once it has gone out
    assign data_req_o   = idle ? acc.req : (state == ST_WAIT_ADDR);
    assign data_wr_o    = idle ? acc.wr : saved_wr;
    assign data_size_o  = idle ? acc.size : saved_size;
    assign data_addr_o  = idle ? acc.addr : saved_addr;
    assign data_wdata_o = idle ? acc.wdata : saved_wdata;

    // Drops in the cycle the data acknowledge shows up
    assign stall_o = data_req_o || (!idle && !data_data_ok_i);

    assign load_done_o  = (state == ST_WAIT_DATA) && data_data_ok_i && !saved_wr;
    assign saved_op_o   = saved_op;
    assign saved_lane_o = saved_addr[LANE_BITS-1:0];
    assign saved_rd_o   = saved_rd;

endmodule

/* source/load_align.sv */
module load_align (
    input  mem_pkg::mem_op_e              op_i,
    input  logic [mem_pkg::LANE_BITS-1:0] lane_i,
    input  mem_pkg::word_t                rdata_i,
    output mem_pkg::word_t                value_o
);
    import mem_pkg::*;

    bus_word_u   word;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign word = rdata_i;

    assign lane_byte = word.bytes[lane_i];
    // Upper lane bit picks the halfword
    assign lane_half = word.halves[lane_i[LANE_BITS-1]];

    always_comb begin
        case (op_i)
            OP_LB: begin
                value_o = {{24{lane_byte[7]}}, lane_byte};
            end
            OP_LBU: begin
                value_o = {24'h000000, lane_byte};
            end
            OP_LH: begin
                value_o = {{16{lane_half[15]}}, lane_half};
            end
            OP_LHU: begin
                value_o = {16'h0000, lane_half};
            end
            OP_LW: begin
                value_o = rdata_i;
            end
            default: begin
                value_o = rdata_i;
            end
        endcase
    end

endmodule

/* source/mem_stage.sv */
module mem_stage (
    input  logic               clk,
    input  logic               rst,

    // Pipeline side
    input  logic               valid_i,
    input  mem_pkg::mem_op_e   op_i,
    input  mem_pkg::word_t     addr_i,
    input  mem_pkg::word_t     store_data_i,
    input  mem_pkg::reg_addr_t rd_i,
    input  logic               wreg_i,
    input  mem_pkg::word_t     alu_result_i,
    output logic               stall_o,
    output logic               wreg_o,
    output mem_pkg::reg_addr_t wd_o,
    output mem_pkg::word_t     wdata_o,
    output mem_pkg::exc_code_e exc_o,

    // Data bus
    output logic               data_req_o,
    output logic               data_wr_o,
    output mem_pkg::acc_size_e data_size_o,
    output mem_pkg::word_t     data_addr_o,
    output mem_pkg::word_t     data_wdata_o,
    input  mem_pkg::word_t     data_rdata_i,
    input  logic               data_addr_ok_i,
    input  logic               data_data_ok_i
);
    import mem_pkg::*;

    mem_access_if acc_if ();

    logic                 load_done;
    mem_op_e              saved_op;
    logic [LANE_BITS-1:0] saved_lane;
    reg_addr_t            saved_rd;
    word_t                load_value;
    logic                 pass_through;

    mem_access_decode i_decode (
        .valid_i      (valid_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .rd_i         (rd_i),
        .exc_o        (exc_o),
        .acc          (acc_if.decoder)
    );

    mem_bus_ctrl i_bus_ctrl (
        .clk            (clk),
        .rst            (rst),
        .data_addr_ok_i (data_addr_ok_i),
        .data_data_ok_i (data_data_ok_i),
        .acc            (acc_if.ctrl),
        .data_req_o     (data_req_o),
        .data_wr_o      (data_wr_o),
        .data_size_o    (data_size_o),
        .data_addr_o    (data_addr_o),
        .data_wdata_o   (data_wdata_o),
        .stall_o        (stall_o),
        .load_done_o    (load_done),
        .saved_op_o     (saved_op),
        .saved_lane_o   (saved_lane),
        .saved_rd_o     (saved_rd)
    );

    load_align i_load_align (
        .op_i    (saved_op),
        .lane_i  (saved_lane),
        .rdata_i (data_rdata_i),
        .value_o (load_value)
    );

    // Non-memory ops go straight to writeback
    assign pass_through = valid_i && (op_i == OP_NONE);

    assign wreg_o  = load_done || (pass_through && wreg_i);
    assign wd_o    = load_done ? saved_rd : rd_i;
    assign wdata_o = load_done ? load_value : alu_result_i;

endmodule

/* tb/mem_stage_checker.sv */
module mem_stage_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exp_valid_i,
    input  mem_pkg::mem_op_e     op_i,
    input  logic [31:0]          addr_i,
    input  logic [31:0]          data_i,
    input  logic [4:0]           rd_i,
    input  logic                 wreg_i,
    input  mem_pkg::exc_code_e   exp_exc_i,
    input  logic [31:0]          exp_wdata_i,
    input  logic                 stall_i,
    input  logic                 wreg_out_i,
    input  logic [4:0]           wd_i,
    input  logic [31:0]          wdata_i,
    input  mem_pkg::exc_code_e   exc_i,
    input  logic                 data_req_i,
    input  logic                 data_wr_i,
    input  logic [1:0]           data_size_i,
    input  logic [31:0]          data_addr_i,
    input  logic [31:0]          data_wdata_i,
    input  logic                 data_addr_ok_i,
    input  logic                 data_data_ok_i,
    output int                   check_count_o,
    output int                   error_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    int   checks = 0;
    int   errors = 0;
    logic is_store;
    logic aligned_mem;

    assign is_store      = op_i inside {OP_SB, OP_SH, OP_SW};
    assign check_count_o = checks;
    assign error_count_o = errors;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %s: got 0x%08h, expected 0x%08h at %0t", name, got, expected, $time);
        end
    endtask

    // Bus fields at the acceptance cycle
    task automatic check_request;
        logic [1:0]  size;
        logic [31:0] lanes;
        size  = 2'd2;
        lanes = data_i;
        if (op_i inside {OP_LB, OP_LBU, OP_SB}) begin
            size  = 2'd0;
            lanes = {4{data_i[7:0]}};
        end else if (op_i inside {OP_LH, OP_LHU, OP_SH}) begin
            size  = 2'd1;
            lanes = {2{data_i[15:0]}};
        end
        compare_value("data_wr_o", 32'(data_wr_i), 32'(is_store));
        compare_value("data_size_o", 32'(data_size_i), 32'(size));
        compare_value("data_addr_o", data_addr_i, addr_i);
        if (is_store) begin
            compare_value("data_wdata_o", data_wdata_i, lanes);
        end
    endtask

    task automatic check_completion;
        compare_value("exc_o", 32'(exc_i), 32'(exp_exc_i));
        if (op_i == OP_NONE || exp_exc_i != EXC_NONE) begin
            compare_value("data_req_o", 32'(data_req_i), 32'h0);
        end
        if (op_i == OP_NONE) begin
            compare_value("wreg_o", 32'(wreg_out_i), 32'(wreg_i));
        end else begin
            compare_value("wreg_o", 32'(wreg_out_i), 32'(!is_store && exp_exc_i == EXC_NONE));
        end
        if (op_i == OP_NONE || (!is_store && exp_exc_i == EXC_NONE)) begin
            compare_value("wd_o", 32'(wd_i), 32'(rd_i));
            compare_value("wdata_o", wdata_i, exp_wdata_i);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            compare_value("data_req_o", 32'(data_req_i), 32'h0);
            compare_value("stall_o", 32'(stall_i), 32'h0);
            compare_value("wreg_o", 32'(wreg_out_i), 32'h0);
            compare_value("exc_o", 32'(exc_i), 32'(EXC_NONE));
        end else if (exp_valid_i) begin
            aligned_mem = (op_i != OP_NONE) && (exp_exc_i == EXC_NONE);
            // Busy until the data acknowledge
            compare_value("stall_o", 32'(stall_i), 32'(aligned_mem && !data_data_ok_i));
            if (data_req_i && data_addr_ok_i) begin
                check_request();
            end
            if (!stall_i) begin
                check_completion();
            end
        end
    end

endmodule

/* tb/mem_stage_tb.sv */
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          MEM_WORDS    = 64;
    localparam int          STIM_WORDS   = 256;
    localparam int          MAX_OPS      = 36;
    localparam int          OP_TIMEOUT   = 40;
    localparam logic [15:0] LFSR_SEED    = 16'd57173;

    logic        clk;
    logic        rst;
    logic        valid;
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] op_data;
    logic [4:0]  rd;
    logic        wreg;
    logic        stall;
    logic        wreg_out;
    logic [4:0]  wd;
    logic [31:0] wdata;
    exc_code_e   exc;
    logic        data_req;
    logic        data_wr;
    logic [1:0]  data_size;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        data_addr_ok;
    logic        data_data_ok;

    // Expected results of the operation on the inputs
    logic        exp_valid;
    exc_code_e   exp_exc;
    logic [31:0] exp_wdata;

    int          check_count;
    int          error_count;
    logic [15:0] lfsr_state;
    logic [31:0] stim [STIM_WORDS];
    logic [31:0] bus_mem [MEM_WORDS];

    mem_stage i_dut (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (valid),
        .op_i           (op),
        .addr_i         (addr),
        .store_data_i   (op_data),
        .rd_i           (rd),
        .wreg_i         (wreg),
        .alu_result_i   (op_data),
        .stall_o        (stall),
        .wreg_o         (wreg_out),
        .wd_o           (wd),
        .wdata_o        (wdata),
        .exc_o          (exc),
        .data_req_o     (data_req),
        .data_wr_o      (data_wr),
        .data_size_o    (data_size),
        .data_addr_o    (data_addr),
        .data_wdata_o   (data_wdata),
        .data_rdata_i   (data_rdata),
        .data_addr_ok_i (data_addr_ok),
        .data_data_ok_i (data_data_ok)
    );

    mem_stage_checker i_checker (
        .clk            (clk),
        .rst            (rst),
        .exp_valid_i    (exp_valid),
        .op_i           (op),
        .addr_i         (addr),
        .data_i         (op_data),
        .rd_i           (rd),
        .wreg_i         (wreg),
        .exp_exc_i      (exp_exc),
        .exp_wdata_i    (exp_wdata),
        .stall_i        (stall),
        .wreg_out_i     (wreg_out),
        .wd_i           (wd),
        .wdata_i        (wdata),
        .exc_i          (exc),
        .data_req_i     (data_req),
        .data_wr_i      (data_wr),
        .data_size_i    (data_size),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .data_addr_ok_i (data_addr_ok),
        .data_data_ok_i (data_data_ok),
        .check_count_o  (check_count),
        .error_count_o  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_two_bits(output logic [1:0] bits);
        bits = 2'b00;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[0], lfsr_state[0]};
        end
    endtask

    // Only the lanes picked by size and address change
    task automatic write_lanes(input logic [31:0] a, input logic [1:0] size,
                               input logic [31:0] d);
        case (size)
            2'd0: bus_mem[a[7:2]][{a[1:0], 3'b000} +: 8] = d[{a[1:0], 3'b000} +: 8];
            2'd1: bus_mem[a[7:2]][{a[1], 4'b0000} +: 16] = d[{a[1], 4'b0000} +: 16];
            default: bus_mem[a[7:2]] = d;
        endcase
    endtask

    initial begin : bus_responder
        logic [1:0]  bits;
        logic        busy;
        logic [31:0] acc_addr;
        int          addr_wait;
        int          data_wait;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        data_rdata   = 32'h0;
        busy         = 1'b0;
        acc_addr     = 32'h0;
        data_wait    = 0;
        bus_mem      = '{default: 32'h0};
        lfsr_state   = LFSR_SEED;
        draw_two_bits(bits);
        addr_wait = int'(bits);
        forever begin
            @(posedge clk);
            #1;
            data_addr_ok = !busy && (addr_wait == 0);
            data_data_ok = busy && (data_wait == 0);
            data_rdata   = data_data_ok ? bus_mem[acc_addr[7:2]] : 32'h0;
            @(negedge clk);
            if (rst) begin
                busy = 1'b0;
            end else if (data_data_ok) begin
                busy = 1'b0;
                draw_two_bits(bits);
                addr_wait = int'(bits);
            end else if (busy) begin
                data_wait = data_wait - 1;
            end else if (data_req && data_addr_ok) begin
                busy     = 1'b1;
                acc_addr = data_addr;
                if (data_wr) begin
                    write_lanes(data_addr, data_size, data_wdata);
                end
                // Data acknowledge 1 to 3 cycles later
                draw_two_bits(bits);
                data_wait = (bits == 2'd0) ? 0 : int'(bits) - 1;
            end else if (data_req) begin
                addr_wait = addr_wait - 1;
            end
        end
    end

    initial begin : driver
        logic [7:0] base;
        logic       timed_out;
        logic       done;
        int         n_ops;
        int         wait_cycles;
        rst       = 1'b1;
        valid     = 1'b0;
        op        = OP_NONE;
        addr      = 32'h0;
        op_data   = 32'h0;
        rd        = 5'h0;
        wreg      = 1'b0;
        exp_valid = 1'b0;
        exp_exc   = EXC_NONE;
        exp_wdata = 32'h0;
        timed_out = 1'b0;
        base      = 8'h0;
        n_ops     = 0;
        $readmemh("tb/mem_stage_stimulus.txt", stim);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!timed_out && n_ops < MAX_OPS && stim[base][3:0] != 4'hf) begin
            valid     = 1'b1;
            op        = mem_op_e'(stim[base][3:0]);
            addr      = stim[base + 8'd1];
            op_data   = stim[base + 8'd2];
            rd        = stim[base + 8'd3][4:0];
            wreg      = stim[base + 8'd4][0];
            exp_exc   = exc_code_e'(stim[base + 8'd5][4:0]);
            exp_wdata = stim[base + 8'd6];
            exp_valid = 1'b1;
            // Held while the stage stalls
            done        = 1'b0;
            wait_cycles = 0;
            while (!done && !timed_out) begin
                @(negedge clk);
                if (!stall) begin
                    done = 1'b1;
                end else if (wait_cycles == OP_TIMEOUT) begin
                    $display("Timeout: operation %0d still stalled after %0d cycles",
                             n_ops, OP_TIMEOUT);
                    timed_out = 1'b1;
                end
                wait_cycles++;
            end
            @(posedge clk);
            #1;
            n_ops++;
            base = base + 8'd7;
        end
        valid     = 1'b0;
        op        = OP_NONE;
        exp_valid = 1'b0;
        repeat (2) @(posedge clk);
        $display("Done: %0d operations, %0d checks, %0d errors, %0d timeouts",
                 n_ops, check_count, error_count, 32'(timed_out));
        if (timed_out || error_count != 0 || check_count == 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

/* tb/mem_stage_stimulus.txt */
// op addr data rd wreg exc expected_wdata, all hex, one operation per line
// op: 0 none, 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 sb, 7 sh, 8 sw, f ends the list
0 00000000 12345678 03 1 00 12345678
0 00000000 cafef00d 1f 0 00 cafef00d
8 00000010 89abcdef 00 0 00 00000000
5 00000010 00000000 07 1 00 89abcdef
1 00000010 00000000 08 1 00 ffffffef
2 00000011 00000000 09 1 00 000000cd
1 00000012 00000000 0a 1 00 ffffffab
2 00000013 00000000 0b 1 00 00000089
3 00000010 00000000 0c 1 00 ffffcdef
4 00000012 00000000 0d 1 00 000089ab
6 00000021 000000a5 00 0 00 00000000
7 00000022 00007e3c 00 0 00 00000000
6 00000020 ffffff11 00 0 00 00000000
5 00000020 00000000 0e 1 00 7e3ca511
1 00000023 00000000 0f 1 00 0000007e
3 00000020 00000000 10 1 00 ffffa511
4 00000022 00000000 11 1 00 00007e3c
1 00000021 00000000 12 1 00 ffffffa5
3 00000021 00000000 13 1 04 00000000
4 00000023 00000000 14 1 04 00000000
5 00000022 00000000 15 1 04 00000000
7 00000013 0000beef 00 0 05 00000000
8 00000011 01020304 00 0 05 00000000
5 00000010 00000000 16 1 00 89abcdef
0 00000000 deadbeef 1d 1 00 deadbeef
f 00000000 00000000 00 0 00 00000000

/* build.f */
source/mem_pkg.sv
source/mem_access_if.sv
source/mem_access_decode.sv
source/mem_bus_ctrl.sv
source/load_align.sv
source/mem_stage.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := mem_stage_tb
RTL_TOP    := mem_stage
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/100ps -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
